// File: hw/burst_framer.sv
// Groups strobed words into fixed bursts, stamps the first word's time and numbers each burst
`default_nettype none
`include "radio_rx_cfg.svh"

module burst_framer
  import radio_rx_pkg::*;
(
  input  wire logic        radio_clk,
  input  wire logic        radio_rst,
  input  wire sample_bus_t sample_bus,
  input  wire radio_time_t radio_time,   // Time of the word now on sample_bus
  output burst_beat_t      framed_beat,
  output burst_desc_t      burst_info    // Checksum left zero for the output stage
);

  localparam int BURST_LEN = `RADIO_BURST_LEN;
  localparam int POS_W     = $clog2(BURST_LEN);
  localparam int SEQ_W     = `RADIO_SEQ_W;

  framer_state_e    state_q;
  logic [POS_W-1:0] pos_q;       // Index of the next word in the burst
  logic [63:0]      stamp_q;     // First word's time
  logic             pps_acc_q;   // PPS seen so far in this burst
  logic [SEQ_W-1:0] seq_q;
  beat_kind_e       kind;
  logic             last_word;
  logic             burst_pps;   // Including the current word

  // ----------------------------------------
  // Position decode
  // ----------------------------------------
  always_comb begin
    if (state_q == FR_IDLE) begin
      kind = BEAT_FIRST;
    end else if (pos_q == POS_W'(BURST_LEN - 1)) begin
      kind = BEAT_LAST;
    end else begin
      kind = BEAT_MID;
    end
  end

  assign last_word = sample_bus.strobe && (kind == BEAT_LAST);
  assign burst_pps = pps_acc_q | radio_time.pps;

  // ----------------------------------------
  // Burst FSM
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state_q   <= FR_IDLE;
      pos_q     <= '0;
      pps_acc_q <= 1'b0;
      seq_q     <= '0;
    end else if (sample_bus.strobe) begin
      case (kind)
        BEAT_FIRST: begin
          state_q   <= FR_COLLECT;
          pos_q     <= POS_W'(1);
          pps_acc_q <= radio_time.pps;        // Fresh start per burst
        end
        BEAT_MID: begin
          pos_q     <= pos_q + 1'b1;
          pps_acc_q <= burst_pps;
        end
        default: begin                         // Closing word
          state_q <= FR_IDLE;
          pos_q   <= '0;
          seq_q   <= seq_q + 1'b1;
        end
      endcase
    end
  end

  // Beat and descriptor registers, one cycle behind the strobe
  always_ff @(posedge radio_clk) begin
    framed_beat.valid <= sample_bus.strobe;
    burst_info.valid  <= last_word;
    if (sample_bus.strobe) begin
      framed_beat.kind <= kind;
      framed_beat.data <= sample_bus.data;
      if (kind == BEAT_FIRST) stamp_q <= radio_time.ticks;
    end
    if (last_word) begin
      burst_info.seq      <= seq_q;
      burst_info.ticks    <= stamp_q;
      burst_info.pps      <= burst_pps;
      burst_info.checksum <= '0;
    end
    if (radio_rst) begin
      framed_beat.valid <= 1'b0;
      burst_info.valid  <= 1'b0;
    end
  end

  // A burst opens only from idle, and idle always opens a burst
  a_first_iff_idle: assert property (@(posedge radio_clk) disable iff (radio_rst)
    framed_beat.valid |-> ((framed_beat.kind == BEAT_FIRST) == ($past(state_q) == FR_IDLE)))
    else $error("beat kind out of step with framer state");

endmodule

`default_nettype wire

// File: hw/burst_output.sv
// Output stage: registers beats, folds them into an XOR checksum, sends the trailer on the last
`default_nettype none

module burst_output
  import radio_rx_pkg::*;
(
  input  wire logic        radio_clk,
  input  wire logic        radio_rst,
  input  wire burst_beat_t framed_beat,
  input  wire burst_desc_t burst_info,   // Arrives with the BEAT_LAST beat
  output burst_beat_t      out_beat,
  output burst_desc_t      trailer
);

  radio_word_t csum_q;      // XOR of the burst so far
  radio_word_t csum_next;   // Including the incoming beat

  // ----------------------------------------
  // Running checksum
  // ----------------------------------------
  // A first beat restarts the sum, so a dropped burst end cannot leak forward
  assign csum_next = (framed_beat.kind == BEAT_FIRST) ? framed_beat.data
                                                      : csum_q ^ framed_beat.data;

  // ----------------------------------------
  // Beat and trailer registers
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    out_beat.valid <= framed_beat.valid;
    trailer.valid  <= burst_info.valid;
    if (framed_beat.valid) begin
      out_beat.kind <= framed_beat.kind;
      out_beat.data <= framed_beat.data;
      csum_q        <= csum_next;
    end
    if (burst_info.valid) begin
      trailer.seq      <= burst_info.seq;
      trailer.ticks    <= burst_info.ticks;
      trailer.pps      <= burst_info.pps;
      // Framer sends a zero seed here
      trailer.checksum <= burst_info.checksum ^ csum_next;
    end
    if (radio_rst) begin
      out_beat.valid <= 1'b0;
      trailer.valid  <= 1'b0;
      csum_q         <= '0;
    end
  end

  // Framer and this stage must agree on where a burst ends
  a_trailer_on_last: assert property (@(posedge radio_clk) disable iff (radio_rst)
    trailer.valid |-> (out_beat.valid && out_beat.kind == BEAT_LAST))
    else $error("trailer not aligned with the last beat");

endmodule

`default_nettype wire

// File: hw/radio_rx_cfg.svh
// Build-time sizes and rates of the receive front end; include wherever a value is needed
`ifndef RADIO_RX_CFG_SVH
`define RADIO_RX_CFG_SVH

// ----------------------------------------
// Sample word shape
// ----------------------------------------
`define RADIO_NSPC        2    // Samples per word
`define RADIO_SAMP_W      16   // Bits per sample
`define RADIO_NUM_CH      2    // Channels packed in one word

// ----------------------------------------
// Source rate and radio time
// ----------------------------------------
`define RADIO_STB_THRESH  128  // Strobe odds, out of 256
`define RADIO_TIME_INC    2    // Ticks per strobed word
`define RADIO_PPS_PERIOD  50   // Must be a whole number of time steps

// ----------------------------------------
// Framing
// ----------------------------------------
`define RADIO_BURST_LEN   4    // Words per burst, two or more
`define RADIO_SEQ_W       8    // Burst counter width, wraps

`endif

// File: hw/radio_rx_pkg.sv
// Shared bus structs and enums of the receive chain; imported by each block and the testbench
`default_nettype none
`include "radio_rx_cfg.svh"

package radio_rx_pkg;

  // One word holds every channel, channel n in the n-th slice
  localparam int RADIO_WORD_W = `RADIO_NUM_CH * `RADIO_NSPC * `RADIO_SAMP_W;

  typedef logic [RADIO_WORD_W-1:0] radio_word_t;

  typedef struct packed {
    logic        strobe;  // One word this cycle
    radio_word_t data;
  } sample_bus_t;

  typedef struct packed {
    logic        load;    // Pulse, applied at next edge
    logic [63:0] value;   // Should sit on a PPS boundary
  } time_cmd_t;

  typedef struct packed {
    logic [63:0] ticks;   // Time of the word on the bus
    logic        pps;     // Nonzero multiple of the PPS period
  } radio_time_t;

  typedef enum logic [1:0] {BEAT_FIRST, BEAT_MID, BEAT_LAST} beat_kind_e;

  typedef struct packed {
    logic        valid;
    beat_kind_e  kind;
    radio_word_t data;
  } burst_beat_t;

  typedef struct packed {
    logic                    valid;
    logic [`RADIO_SEQ_W-1:0] seq;       // Burst number since reset
    logic [63:0]             ticks;     // Time of first word
    logic                    pps;       // Burst touched a PPS edge
    radio_word_t             checksum;  // XOR over the burst's words
  } burst_desc_t;

  typedef enum logic {FR_IDLE, FR_COLLECT} framer_state_e;

endpackage

`default_nettype wire

// File: hw/radio_rx_top.sv
// Receive front end top: source, timekeeper, framer and output stage in one chain
`default_nettype none

module radio_rx_top
  import radio_rx_pkg::*;
(
  input  wire logic      radio_clk,
  input  wire logic      radio_rst,
  input  wire logic      rx_enable,
  input  wire time_cmd_t time_cmd,
  output radio_time_t    radio_time,
  output burst_beat_t    out_beat,
  output burst_desc_t    trailer
);

  sample_bus_t sample_bus;    // Source to framer and timekeeper
  burst_beat_t framed_beat;   // Framer to output stage
  burst_desc_t burst_info;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  radio_sample_gen sample_gen_i (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .rx_enable  (rx_enable),
    .sample_bus (sample_bus)
  );

  radio_timekeeper timekeeper_i (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .sample_bus (sample_bus),
    .time_cmd   (time_cmd),
    .radio_time (radio_time)
  );

  // ----------------------------------------
  // Framing and output
  // ----------------------------------------
  burst_framer framer_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .sample_bus  (sample_bus),
    .radio_time  (radio_time),
    .framed_beat (framed_beat),
    .burst_info  (burst_info)
  );

  burst_output output_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .framed_beat (framed_beat),
    .burst_info  (burst_info),
    .out_beat    (out_beat),
    .trailer     (trailer)
  );

endmodule

`default_nettype wire

// File: hw/radio_sample_gen.sv
// Ramp sample source where an LFSR picks strobe cycles and every channel counts up by NSPC per word
`default_nettype none
`include "radio_rx_cfg.svh"

module radio_sample_gen
  import radio_rx_pkg::*;
(
  input  wire logic radio_clk,
  input  wire logic radio_rst,
  input  wire logic rx_enable,   // No words while low
  output sample_bus_t sample_bus
);

  localparam logic [15:0] LFSR_SEED = 16'hACE1;
  localparam int          NSPC      = `RADIO_NSPC;
  localparam int          SAMP_W    = `RADIO_SAMP_W;
  localparam int          NUM_CH    = `RADIO_NUM_CH;

  typedef logic [SAMP_W-1:0] sample_t;

  // Channel n starts at n/NUM_CH of full scale with its samples one apart
  function automatic radio_word_t ramp_init();
    radio_word_t word;
    sample_t     base;
    word = '0;
    for (int n = 0; n < NUM_CH; n++) begin
      base = sample_t'((longint'(n) << SAMP_W) / NUM_CH);
      for (int s = 0; s < NSPC; s++) begin
        word[(n*NSPC + s)*SAMP_W +: SAMP_W] = base + sample_t'(s);
      end
    end
    return word;
  endfunction

  logic [15:0] lfsr_q;
  logic        lfsr_fb;     // Taps 16, 14, 13, 11
  logic        fire;        // Word goes out at the next edge
  logic        strobe_q;
  radio_word_t ramp_q;      // All channel counters side by side

  // ----------------------------------------
  // Strobe pattern
  // ----------------------------------------
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  assign fire    = rx_enable && ({1'b0, lfsr_q[7:0]} < 9'(`RADIO_STB_THRESH));

  // ----------------------------------------
  // Ramp counters
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      lfsr_q   <= LFSR_SEED;
      strobe_q <= 1'b0;
      ramp_q   <= ramp_init();                  // Back to the k=0 pattern
    end else begin
      lfsr_q   <= {lfsr_q[14:0], lfsr_fb};     // Steps every cycle
      strobe_q <= fire;
      if (fire) begin
        for (int i = 0; i < NUM_CH*NSPC; i++) begin
          ramp_q[i*SAMP_W +: SAMP_W] <= ramp_q[i*SAMP_W +: SAMP_W] + sample_t'(NSPC);
        end
      end
    end
  end

  assign sample_bus = '{strobe: strobe_q, data: ramp_q};

  // Strobe stays low for as long as reset is held
  a_no_strobe_in_rst: assert property (@(posedge radio_clk)
    radio_rst |-> !sample_bus.strobe)
    else $error("sample strobe high during reset");

endmodule

`default_nettype wire

// File: hw/radio_timekeeper.sv
// Radio time counter stepped by each sample strobe, with time load and a PPS alignment flag
`default_nettype none
`include "radio_rx_cfg.svh"

module radio_timekeeper
  import radio_rx_pkg::*;
(
  input  wire logic        radio_clk,
  input  wire logic        radio_rst,
  input  wire sample_bus_t sample_bus,   // Only the strobe matters here
  input  wire time_cmd_t   time_cmd,
  output radio_time_t      radio_time
);

  localparam int TIME_INC   = `RADIO_TIME_INC;
  localparam int PPS_PERIOD = `RADIO_PPS_PERIOD;
  localparam int PH_W       = $clog2(PPS_PERIOD + 1);

  logic [63:0]     ticks_q;
  logic [PH_W-1:0] phase_q;      // Ticks past the last PPS boundary
  logic            phase_wrap;   // Next step lands on a boundary

  // Phase steps by TIME_INC and must hit zero exactly
  initial begin
    assert (PPS_PERIOD % TIME_INC == 0)
      else $fatal(1, "PPS period is not a whole number of time steps");
  end

  // ----------------------------------------
  // Time and phase
  // ----------------------------------------
  assign phase_wrap = (int'(phase_q) + TIME_INC) >= PPS_PERIOD;

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      ticks_q <= '0;
      phase_q <= '0;
    end else if (time_cmd.load) begin          // Load beats a same-cycle strobe
      ticks_q <= time_cmd.value;
      phase_q <= '0;                            // Loads are PPS aligned
    end else if (sample_bus.strobe) begin
      ticks_q <= ticks_q + 64'(TIME_INC);
      phase_q <= phase_wrap ? '0 : phase_q + PH_W'(TIME_INC);
    end
  end

  // Time shown is that of the word on the bus right now
  assign radio_time = '{
    ticks: ticks_q,
    pps:   (phase_q == '0) && (ticks_q != '0)  // Time zero is not a PPS edge
  };

  // Phase tracking only holds if every load sits on a boundary
  a_load_on_pps: assert property (@(posedge radio_clk) disable iff (radio_rst)
    time_cmd.load |-> (time_cmd.value % 64'(PPS_PERIOD)) == 64'd0)
    else $error("time load off the PPS grid, pps flag will drift");

endmodule

`default_nettype wire

// File: radio_rx.f
+incdir+hw
hw/radio_rx_pkg.sv
hw/radio_sample_gen.sv
hw/radio_timekeeper.sv
hw/burst_framer.sv
hw/burst_output.sv
hw/radio_rx_top.sv
test/tb_clock_gen.sv
test/radio_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the radio_rx testbench with Verilator, runs it and scans the log for failure
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f radio_rx.f --top-module radio_rx_tb -o radio_rx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/radio_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

// File: test/radio_rx_tb.sv
// Top testbench that drives random enables and time loads and checks all outputs against a model
`default_nettype none
`include "radio_rx_cfg.svh"

module radio_rx_tb
  import radio_rx_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RUN_CYCLES     = 2000;
  localparam int DRAIN_CYCLES   = 8;                   // Lets in-flight beats come out
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;
  localparam int MIN_BURSTS     = 20;
  localparam int NSPC = `RADIO_NSPC;
  localparam int SAMP_W = `RADIO_SAMP_W;
  localparam int NUM_CH = `RADIO_NUM_CH;
  localparam int BURST_LEN = `RADIO_BURST_LEN;
  localparam longint PPS_PERIOD = `RADIO_PPS_PERIOD;

  logic radio_clk, radio_rst, rx_enable;
  time_cmd_t time_cmd;
  radio_time_t radio_time;
  burst_beat_t out_beat;
  burst_desc_t trailer;

  logic [31:0] lfsr_q;                        // Stimulus LFSR state
  int en_left, load_left, stim_cycles, cycles, hist_cnt;
  int beat_errs, trl_errs, time_errs, bursts;
  int unsigned beat_k;                        // Strobed words seen since reset
  int pos;                                    // Model position in burst
  logic [63:0] ticks_m, acc_time;             // Time of word two cycles back
  logic acc_pps;
  radio_word_t acc_csum;
  logic [`RADIO_SEQ_W-1:0] seq_m;
  radio_time_t rt_hist [2];                   // Index 1 is two cycles old
  time_cmd_t cmd_hist [2];

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(5)) clock_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst)
  );

  radio_rx_top dut_i (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .rx_enable  (rx_enable),
    .time_cmd   (time_cmd),
    .radio_time (radio_time),
    .out_beat   (out_beat),
    .trailer    (trailer)
  );

  // ----------------------------------------
  // Random source and reference rules
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Word k puts sample s of channel n at n/NUM_CH of full scale plus s plus k*NSPC
  function automatic radio_word_t ramp_word(int unsigned k);
    radio_word_t w;
    longint unsigned v;
    w = '0;
    for (int n = 0; n < NUM_CH; n++) begin
      for (int s = 0; s < NSPC; s++) begin
        v = ((longint'(n) << SAMP_W) / NUM_CH) + longint'(s) + longint'(k) * NSPC;
        w[(n*NSPC + s)*SAMP_W +: SAMP_W] = v[SAMP_W-1:0];  // Wraps at sample width
      end
    end
    return w;
  endfunction

  function automatic logic pps_at(logic [63:0] t);
    return (t != 64'd0) && (t % 64'(PPS_PERIOD) == 64'd0);
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_beat(input burst_beat_t exp, input burst_beat_t got);
    beat_kind_e gk, ek;
    gk = got.kind;
    ek = exp.kind;
    if (got.kind !== exp.kind || got.data !== exp.data) begin
      beat_errs++;
      $display("error %0t: beat %0d is %s %h, expected %s %h", $time, beat_k,
               gk.name(), got.data, ek.name(), exp.data);
    end
  endtask

  task automatic check_trailer(input burst_desc_t exp, input burst_desc_t got);
    if (got.valid !== exp.valid) begin
      trl_errs++;
      $display("error %0t: trailer valid %b, expected %b", $time, got.valid, exp.valid);
    end else if (exp.valid && (got.seq !== exp.seq || got.ticks !== exp.ticks ||
                 got.pps !== exp.pps || got.checksum !== exp.checksum)) begin
      trl_errs++;
      $display("error %0t: trailer seq %0d t %0d pps %b sum %h, expected %0d %0d %b %h",
               $time, got.seq, got.ticks, got.pps, got.checksum,
               exp.seq, exp.ticks, exp.pps, exp.checksum);
    end
  endtask

  task automatic check_time(input radio_time_t exp, input radio_time_t got);
    if (got.ticks !== exp.ticks || got.pps !== exp.pps) begin
      time_errs++;
      $display("error %0t: radio time %0d pps %b, expected %0d pps %b", $time,
               got.ticks, got.pps, exp.ticks, exp.pps);
    end
  endtask

  // ----------------------------------------
  // Model step on each falling edge
  // ----------------------------------------
  task automatic reset_model();
    ticks_m = '0;
    seq_m = '0;
    beat_k = 0;
    pos = 0;
    hist_cnt = 0;
  endtask

  task automatic check_cycle();
    burst_beat_t exp_beat;
    burst_desc_t exp_trl;
    exp_trl = '0;
    if (hist_cnt >= 2) check_time('{ticks: ticks_m, pps: pps_at(ticks_m)}, rt_hist[1]);
    if (out_beat.valid) begin               // Beat of the strobe two cycles back
      beat_k++;
      exp_beat.valid = 1'b1;
      exp_beat.kind = (pos == 0) ? BEAT_FIRST : (pos == BURST_LEN-1) ? BEAT_LAST : BEAT_MID;
      exp_beat.data = ramp_word(beat_k);
      check_beat(exp_beat, out_beat);
      if (pos == 0) begin
        acc_time = ticks_m;                 // Stamp is the first word's time
        acc_pps = pps_at(ticks_m);
        acc_csum = exp_beat.data;
      end else begin
        acc_pps = acc_pps | pps_at(ticks_m);
        acc_csum = acc_csum ^ exp_beat.data;
      end
      if (pos == BURST_LEN-1) begin
        exp_trl = '{valid: 1'b1, seq: seq_m, ticks: acc_time, pps: acc_pps,
                    checksum: acc_csum};
        seq_m++;
        bursts++;
      end
      pos = (pos + 1) % BURST_LEN;
    end
    check_trailer(exp_trl, trailer);
    if (cmd_hist[1].load) ticks_m = cmd_hist[1].value;       // Load wins over the step
    else if (out_beat.valid) ticks_m = ticks_m + `RADIO_TIME_INC;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    time_cmd = '0;
    if (en_left == 0) begin                 // Mostly on with short gaps
      rx_enable = !rx_enable;
      if (rx_enable) begin
        random_bits(6, r);
        en_left = 16 + int'(r[5:0]);
      end else begin
        random_bits(4, r);
        en_left = 1 + int'(r[3:0]);
      end
    end else en_left--;
    if (load_left == 0) begin
      random_bits(16, r);
      time_cmd.load = 1'b1;
      time_cmd.value = 64'(r[15:0]) * 64'(PPS_PERIOD);  // On the PPS grid
      random_bits(7, r);
      load_left = 136 + int'(r[6:0]);       // About every 200 cycles
    end else load_left--;
  endtask

  task automatic step_cycle(input logic stimulate);
    @(negedge radio_clk);
    if (radio_rst) begin
      reset_model();
      rx_enable = 1'b0;
      time_cmd = '0;
    end else begin
      check_cycle();
      if (stimulate) begin
        drive_inputs();
        stim_cycles++;
      end else begin
        rx_enable = 1'b0;
        time_cmd = '0;
      end
    end
    rt_hist[1] = rt_hist[0];
    rt_hist[0] = radio_time;
    cmd_hist[1] = cmd_hist[0];
    cmd_hist[0] = time_cmd;                 // What the DUT takes at the next edge
    if (hist_cnt < 2) hist_cnt++;
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------
  initial begin
    rx_enable = 1'b0;
    time_cmd = '0;
    lfsr_q = 32'h1781;
    en_left = 0;
    stim_cycles = 0;
    beat_errs = 0;
    trl_errs = 0;
    time_errs = 0;
    bursts = 0;
    load_left = 100;                        // First load early in the run
    reset_model();
    while (stim_cycles < RUN_CYCLES) step_cycle(1'b1);
    repeat (DRAIN_CYCLES) step_cycle(1'b0);
    if (bursts < MIN_BURSTS)
      $display("only %0d bursts completed, at least %0d were expected", bursts, MIN_BURSTS);
    $display("beat errors %0d, trailer errors %0d, time errors %0d, bursts %0d",
             beat_errs, trl_errs, time_errs, bursts);
    if (beat_errs + trl_errs + time_errs == 0 && bursts >= MIN_BURSTS) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge radio_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("simulation timed out after %0d clock cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and power-on reset source; instantiate once in the testbench top
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,  // Full clock period
  parameter int RST_CYCLES = 5    // Rising edges seen with reset high
) (
  output logic radio_clk,
  output logic radio_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    radio_clk = 1'b0;
    forever #(PERIOD_NS / 2) radio_clk = ~radio_clk;
  end

  // Released with an NBA so the DUT sees the last reset edge cleanly
  initial begin
    radio_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge radio_clk);
    radio_rst <= 1'b0;
  end

endmodule

`default_nettype wire
